// File: project.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/bus_xbar.sv
rtl/data_mem.sv
rtl/timer_regs.sv
rtl/timer_core.sv
rtl/gpio_regs.sv
rtl/soc_top.sv
bench/tb_soc_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_soc_top -o tb_soc_top
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/tb_soc_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi
exit 0

// File: bench/tb_soc_top.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module tb_soc_top;
  import soc_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int POLL_LIMIT     = 100;

  logic                   clk;
  logic                   rst;
  bus_req_t               bus_req;
  bus_rsp_t               bus_rsp;
  logic [`SOC_GPIO_W-1:0] gpio_in;
  logic [`SOC_GPIO_W-1:0] gpio_out;
  logic [`SOC_GPIO_W-1:0] gpio_oe;
  logic                   irq;
  logic                   accepted;
  int                     seed = 32'hcec9;
  logic [31:0]            shadow [32];

  soc_top i_dut (
    .clk_i     (clk),
    .rst_i     (rst),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .irq_o     (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign accepted = bus_req.a_valid & bus_rsp.a_ready;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      stop_on_error($sformatf("FAILED %s: expected %0h actual %0h", name, exp, act));
    end
  endtask

  // response comes back exactly two cycles after acceptance
  assert property (@(posedge clk) disable iff (rst)
    $rose(bus_rsp.d_valid) == $past(accepted, 2))
    else stop_on_error("d_valid did not rise two cycles after the request was accepted");

  assert property (@(posedge clk) disable iff (rst)
    ($past(accepted) || bus_rsp.d_valid) |-> !bus_rsp.a_ready)
    else stop_on_error("a_ready was high while a transaction was pending");

  // stalled response must not move
  assert property (@(posedge clk) disable iff (rst)
    (bus_rsp.d_valid && !bus_req.d_ready) |=>
      (bus_rsp.d_valid && $stable(bus_rsp.d_rdata) && $stable(bus_rsp.d_error)))
    else stop_on_error("response changed while the host held d_ready low");

  assert property (@(posedge clk) disable iff (rst) bus_rsp.d_valid |-> !accepted)
    else stop_on_error("a second request was accepted before the response was taken");

  // a_valid is already high, drops it on the accepting edge
  task automatic hold_until_accepted();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!bus_rsp.a_ready && n < TIMEOUT_CYCLES);
    if (!bus_rsp.a_ready) stop_on_error("bus request was never accepted");
    bus_req.a_valid <= 1'b0;
  endtask

  task automatic wait_for_response();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!bus_rsp.d_valid && n < TIMEOUT_CYCLES);
    if (!bus_rsp.d_valid) stop_on_error("no bus response arrived");
  endtask

  // called right after a rising edge, returns right after one
  task automatic bus_access(input logic write, input logic [15:0] addr, input logic [31:0] wdata,
                            input int stall, output logic [31:0] rdata, output logic err);
    bus_req.a_valid <= 1'b1;
    bus_req.a_write <= write;
    bus_req.a_addr  <= addr;
    bus_req.a_wdata <= wdata;
    bus_req.d_ready <= (stall == 0);
    hold_until_accepted();
    wait_for_response();
    if (stall > 0) begin
      // same access offered again behind the stalled response
      bus_req.a_valid <= 1'b1;
      repeat (stall) @(posedge clk);
      bus_req.d_ready <= 1'b1;
      @(posedge clk);
    end
    rdata = bus_rsp.d_rdata;
    err   = bus_rsp.d_error;
    if (stall > 0) begin
      hold_until_accepted();
      wait_for_response();
    end
  endtask

  task automatic write_reg(input string name, input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b1, addr, data, 0, rd, err);
    check_value({name, " error"}, 32'd0, 32'(err));
    check_value({name, " write data"}, 32'd0, rd);
  endtask

  task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
    logic err;
    bus_access(1'b0, addr, 32'd0, 0, data, err);
    check_value("read error", 32'd0, 32'(err));
  endtask

  task automatic read_check(input string name, input logic [15:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    read_reg(addr, rd);
    check_value(name, exp, rd);
  endtask

  task automatic poll_reg(input string what, input logic [15:0] addr, input logic [31:0] mask,
                          input logic [31:0] value);
    logic [31:0] rd;
    int          n;
    n = 0;
    do begin
      read_reg(addr, rd);
      n++;
    end while ((rd & mask) != value && n < POLL_LIMIT);
    if ((rd & mask) != value) stop_on_error({what, " did not happen in time"});
  endtask

  function automatic logic [15:0] mem_addr(input logic [4:0] idx);
    return {9'd0, idx, 2'b00};
  endfunction

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [4:0]  idx;
    int          stall;
    logic [31:0] first_count;
    logic [31:0] second_count;
    rst     <= 1'b1;
    bus_req <= '0;
    gpio_in <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    bus_req.d_ready <= 1'b1;

    // reset state
    check_value("reset a_ready", 32'd1, 32'(bus_rsp.a_ready));
    check_value("reset d_valid", 32'd0, 32'(bus_rsp.d_valid));
    check_value("reset irq", 32'd0, 32'(irq));
    check_value("reset gpio_o", 32'd0, 32'(gpio_out));
    check_value("reset gpio_oe_o", 32'd0, 32'(gpio_oe));
    read_check("reset timer count", 16'h1004, 32'd0);
    read_check("reset timer compare", 16'h1008, 32'd0);

    // memory fill, then random traffic against the shadow copy
    for (int i = 0; i < 32; i++) begin
      shadow[i] = $random(seed);
      write_reg("mem fill", mem_addr(5'(i)), shadow[i]);
    end
    for (int i = 0; i < 40; i++) begin
      idx = 5'($random(seed));
      if ($random(seed) & 1) begin
        shadow[idx] = $random(seed);
        write_reg("mem write", mem_addr(idx), shadow[idx]);
      end else begin
        read_check("mem read", mem_addr(idx), shadow[idx]);
      end
    end

    // region 3 answers with an error and must not alias into memory
    bus_access(1'b1, 16'h3000, 32'hdeadbeef, 0, rd, err);
    check_value("unmapped write error", 32'd1, 32'(err));
    check_value("unmapped write data", 32'd0, rd);
    bus_access(1'b0, 16'h3000, 32'd0, 0, rd, err);
    check_value("unmapped read error", 32'd1, 32'(err));
    check_value("unmapped read data", 32'd0, rd);
    read_check("mem after unmapped write", mem_addr(5'd0), shadow[0]);

    // host stalls the response for a few cycles
    for (int i = 0; i < 4; i++) begin
      stall = 1 + ($unsigned($random(seed)) % 8);
      idx   = 5'($random(seed));
      bus_access(1'b0, mem_addr(idx), 32'd0, stall, rd, err);
      check_value("stalled read error", 32'd0, 32'(err));
      check_value("stalled read data", shadow[idx], rd);
      shadow[idx] = $random(seed);
      bus_access(1'b1, mem_addr(idx), shadow[idx], stall, rd, err);
      check_value("stalled write error", 32'd0, 32'(err));
      read_check("stalled write read-back", mem_addr(idx), shadow[idx]);
    end

    // gpio outputs, input sync and edge interrupt
    write_reg("gpio out", 16'h2000, 32'h0000a5c3);
    write_reg("gpio oe", 16'h2004, 32'h00000ff0);
    check_value("gpio_o pins", 32'h0000a5c3, 32'(gpio_out));
    check_value("gpio_oe_o pins", 32'h00000ff0, 32'(gpio_oe));
    gpio_in <= 16'h1234;
    poll_reg("gpio input read-back", 16'h2008, 32'h0000ffff, 32'h00001234);
    check_value("gpio irq masked", 32'd0, 32'(irq));
    write_reg("gpio status clear all", 16'h200c, 32'h0000ffff);
    read_check("gpio status cleared", 16'h200c, 32'd0);
    write_reg("gpio irq enable", 16'h2010, 32'h00000001);
    gpio_in <= 16'h1235;
    poll_reg("gpio rising edge status", 16'h200c, 32'h00000001, 32'h00000001);
    check_value("gpio irq set", 32'd1, 32'(irq));
    write_reg("gpio status clear", 16'h200c, 32'h00000001);
    read_check("gpio status after clear", 16'h200c, 32'd0);
    check_value("gpio irq cleared", 32'd0, 32'(irq));

    // timer runs from a loaded count up to compare
    write_reg("timer load", 16'h1004, 32'd100);
    write_reg("timer compare", 16'h1008, 32'd140);
    write_reg("timer enable", 16'h1000, 32'd1);
    read_reg(16'h1004, first_count);
    read_reg(16'h1004, second_count);
    assert (second_count > first_count) else begin
      stop_on_error($sformatf("FAILED timer count: expected above %0d actual %0d",
                              first_count, second_count));
    end
    poll_reg("timer expiry status", 16'h100c, 32'h00000001, 32'h00000001);
    check_value("timer irq masked", 32'd0, 32'(irq));
    write_reg("timer irq enable", 16'h1010, 32'd1);
    check_value("timer irq set", 32'd1, 32'(irq));
    write_reg("timer status clear", 16'h100c, 32'd1);
    check_value("timer irq cleared", 32'd0, 32'(irq));

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: rtl/soc_top.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  soc_pkg::bus_req_t      bus_req_i,
  output soc_pkg::bus_rsp_t      bus_rsp_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o,
  output logic                   irq_o
);
  import soc_pkg::*;

  dev_req_t    xbar_to_dccm;
  dev_rsp_t    dccm_to_xbar;
  dev_req_t    xbar_to_timer;
  dev_rsp_t    timer_to_xbar;
  dev_req_t    xbar_to_gpio;
  dev_rsp_t    gpio_to_xbar;
  timer_cfg_t  timer_cfg;
  timer_stat_t timer_stat;
  logic        intr_timer;
  logic        intr_gpio;

  bus_xbar u_xbar (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .host_req_i  (bus_req_i),
    .host_rsp_o  (bus_rsp_o),
    .mem_req_o   (xbar_to_dccm),
    .timer_req_o (xbar_to_timer),
    .gpio_req_o  (xbar_to_gpio),
    .mem_rsp_i   (dccm_to_xbar),
    .timer_rsp_i (timer_to_xbar),
    .gpio_rsp_i  (gpio_to_xbar)
  );

  data_mem #(
    .WORDS (`SOC_MEM_WORDS)
  ) u_dccm (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (xbar_to_dccm),
    .rsp_o (dccm_to_xbar)
  );

  // timer registers steer the counter
  timer_regs u_timer_regs (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (xbar_to_timer),
    .rsp_o  (timer_to_xbar),
    .cfg_o  (timer_cfg),
    .stat_i (timer_stat),
    .irq_o  (intr_timer)
  );

  timer_core u_timer_core (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cfg_i  (timer_cfg),
    .stat_o (timer_stat)
  );

  gpio_regs u_gpio (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (xbar_to_gpio),
    .rsp_o     (gpio_to_xbar),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_o     (intr_gpio)
  );

  // single interrupt line for the host
  assign irq_o = intr_timer | intr_gpio;

endmodule

// File: rtl/gpio_regs.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module gpio_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  soc_pkg::dev_req_t      req_i,
  output soc_pkg::dev_rsp_t      rsp_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o,
  output logic                   irq_o
);

  localparam logic [`SOC_OFFS_W-1:0] OUT_OFFS    = 'h000;
  localparam logic [`SOC_OFFS_W-1:0] OE_OFFS     = 'h004;
  localparam logic [`SOC_OFFS_W-1:0] IN_OFFS     = 'h008;
  localparam logic [`SOC_OFFS_W-1:0] STATUS_OFFS = 'h00c;
  localparam logic [`SOC_OFFS_W-1:0] INTEN_OFFS  = 'h010;

  logic                   wr;
  logic [`SOC_GPIO_W-1:0] out_q;
  logic [`SOC_GPIO_W-1:0] oe_q;
  logic [`SOC_GPIO_W-1:0] in_meta_q;
  logic [`SOC_GPIO_W-1:0] in_sync_q;
  logic [`SOC_GPIO_W-1:0] in_prev_q;
  logic [`SOC_GPIO_W-1:0] rise;
  logic [`SOC_GPIO_W-1:0] status_q;
  logic [`SOC_GPIO_W-1:0] inten_q;
  logic [`SOC_GPIO_W-1:0] rdata;
  logic                   rsp_valid_q;
  logic [`SOC_DATA_W-1:0] rsp_rdata_q;

  assign wr   = req_i.valid & req_i.write;
  assign rise = in_sync_q & ~in_prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q       <= '0;
      oe_q        <= '0;
      in_meta_q   <= '0;
      in_sync_q   <= '0;
      in_prev_q   <= '0;
      status_q    <= '0;
      inten_q     <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
      // two stage synchronizer, then one more flop for edge detect
      in_meta_q   <= gpio_i;
      in_sync_q   <= in_meta_q;
      in_prev_q   <= in_sync_q;
      if (wr && req_i.offs == OUT_OFFS) out_q <= req_i.wdata[`SOC_GPIO_W-1:0];
      if (wr && req_i.offs == OE_OFFS) oe_q <= req_i.wdata[`SOC_GPIO_W-1:0];
      if (wr && req_i.offs == INTEN_OFFS) inten_q <= req_i.wdata[`SOC_GPIO_W-1:0];
      // new edges win against write-1-to-clear
      if (wr && req_i.offs == STATUS_OFFS) begin
        status_q <= (status_q & ~req_i.wdata[`SOC_GPIO_W-1:0]) | rise;
      end else begin
        status_q <= status_q | rise;
      end
    end
  end

  always_comb begin
    case (req_i.offs)
      OUT_OFFS:    rdata = out_q;
      OE_OFFS:     rdata = oe_q;
      IN_OFFS:     rdata = in_sync_q;
      STATUS_OFFS: rdata = status_q;
      INTEN_OFFS:  rdata = inten_q;
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) rsp_rdata_q <= req_i.write ? '0 : `SOC_DATA_W'(rdata);
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.rdata = rsp_rdata_q;

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign irq_o     = |(status_q & inten_q);

endmodule

// File: rtl/timer_core.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module timer_core (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  soc_pkg::timer_cfg_t  cfg_i,
  output soc_pkg::timer_stat_t stat_o
);

  logic [`SOC_DATA_W-1:0] count_q;

  // load has priority over counting
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (cfg_i.load) begin
      count_q <= cfg_i.load_value;
    end else if (cfg_i.enable) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign stat_o.count = count_q;
  // only a running timer can expire
  assign stat_o.match = cfg_i.enable & (count_q == cfg_i.compare);

endmodule

// File: rtl/timer_regs.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module timer_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  soc_pkg::dev_req_t    req_i,
  output soc_pkg::dev_rsp_t    rsp_o,
  output soc_pkg::timer_cfg_t  cfg_o,
  input  soc_pkg::timer_stat_t stat_i,
  output logic                 irq_o
);

  localparam logic [`SOC_OFFS_W-1:0] CTRL_OFFS   = 'h000;
  localparam logic [`SOC_OFFS_W-1:0] COUNT_OFFS  = 'h004;
  localparam logic [`SOC_OFFS_W-1:0] CMP_OFFS    = 'h008;
  localparam logic [`SOC_OFFS_W-1:0] STATUS_OFFS = 'h00c;
  localparam logic [`SOC_OFFS_W-1:0] INTEN_OFFS  = 'h010;

  logic                   wr;
  logic                   enable_q;
  logic [`SOC_DATA_W-1:0] compare_q;
  logic                   status_q;
  logic                   inten_q;
  logic [`SOC_DATA_W-1:0] rdata;
  logic                   rsp_valid_q;
  logic [`SOC_DATA_W-1:0] rsp_rdata_q;

  assign wr = req_i.valid & req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q    <= 1'b0;
      compare_q   <= '0;
      status_q    <= 1'b0;
      inten_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
      if (wr && req_i.offs == CTRL_OFFS) enable_q <= req_i.wdata[0];
      if (wr && req_i.offs == CMP_OFFS) compare_q <= req_i.wdata;
      if (wr && req_i.offs == INTEN_OFFS) inten_q <= req_i.wdata[0];
      // a match in the same cycle beats the clear
      if (stat_i.match) begin
        status_q <= 1'b1;
      end else if (wr && req_i.offs == STATUS_OFFS && req_i.wdata[0]) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (req_i.offs)
      CTRL_OFFS:   rdata = {{(`SOC_DATA_W-1){1'b0}}, enable_q};
      COUNT_OFFS:  rdata = stat_i.count;
      CMP_OFFS:    rdata = compare_q;
      STATUS_OFFS: rdata = {{(`SOC_DATA_W-1){1'b0}}, status_q};
      INTEN_OFFS:  rdata = {{(`SOC_DATA_W-1){1'b0}}, inten_q};
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) rsp_rdata_q <= req_i.write ? '0 : rdata;
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.rdata = rsp_rdata_q;

  // load pulse comes straight from the count write
  assign cfg_o.enable     = enable_q;
  assign cfg_o.load       = wr & (req_i.offs == COUNT_OFFS);
  assign cfg_o.load_value = req_i.wdata;
  assign cfg_o.compare    = compare_q;

  assign irq_o = status_q & inten_q;

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module data_mem #(
  parameter int WORDS = `SOC_MEM_WORDS
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  soc_pkg::dev_req_t req_i,
  output soc_pkg::dev_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(WORDS);

  logic [`SOC_DATA_W-1:0] mem_q [WORDS];
  logic [IDX_W-1:0]       idx;
  logic                   rsp_valid_q;
  logic [`SOC_DATA_W-1:0] rsp_rdata_q;

  // word index, byte bits already dropped by the crossbar
  assign idx = req_i.offs[2 +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.write) begin
      mem_q[idx] <= req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rsp_rdata_q <= req_i.write ? '0 : mem_q[idx];
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.rdata = rsp_rdata_q;

endmodule

// File: rtl/bus_xbar.sv
`timescale 1ns/1ns
`include "soc_macros.svh"

module bus_xbar (
  input  logic              clk_i,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t host_req_i,
  output soc_pkg::bus_rsp_t host_rsp_o,
  output soc_pkg::dev_req_t mem_req_o,
  output soc_pkg::dev_req_t timer_req_o,
  output soc_pkg::dev_req_t gpio_req_o,
  input  soc_pkg::dev_rsp_t mem_rsp_i,
  input  soc_pkg::dev_rsp_t timer_rsp_i,
  input  soc_pkg::dev_rsp_t gpio_rsp_i
);
  import soc_pkg::*;

  logic                   accept;
  logic [1:0]             region;
  dev_req_t               dev_req;
  logic                   pend_q;
  logic                   wait_q;
  logic [1:0]             region_q;
  logic                   dev_valid;
  logic [`SOC_DATA_W-1:0] dev_rdata;
  logic                   dev_error;
  logic                   rsp_valid_q;
  logic [`SOC_DATA_W-1:0] rsp_rdata_q;
  logic                   rsp_error_q;

  // one transaction in flight, so a_ready simply follows the pending flag
  assign accept = host_req_i.a_valid & ~pend_q;
  assign region = host_req_i.a_addr[`SOC_OFFS_W +: 2];

  assign dev_req.valid = accept;
  assign dev_req.write = host_req_i.a_write;
  assign dev_req.offs  = {host_req_i.a_addr[`SOC_OFFS_W-1:2], 2'b00};
  assign dev_req.wdata = host_req_i.a_wdata;

  always_comb begin
    mem_req_o         = dev_req;
    mem_req_o.valid   = accept & (region == `SOC_REGION_MEM);
    timer_req_o       = dev_req;
    timer_req_o.valid = accept & (region == `SOC_REGION_TIMER);
    gpio_req_o        = dev_req;
    gpio_req_o.valid  = accept & (region == `SOC_REGION_GPIO);
  end

  // pick the answering device, region 3 is answered here with an error
  always_comb begin
    dev_error = 1'b0;
    case (region_q)
      `SOC_REGION_MEM: begin
        dev_valid = mem_rsp_i.valid;
        dev_rdata = mem_rsp_i.rdata;
      end
      `SOC_REGION_TIMER: begin
        dev_valid = timer_rsp_i.valid;
        dev_rdata = timer_rsp_i.rdata;
      end
      `SOC_REGION_GPIO: begin
        dev_valid = gpio_rsp_i.valid;
        dev_rdata = gpio_rsp_i.rdata;
      end
      default: begin
        dev_valid = 1'b1;
        dev_rdata = '0;
        dev_error = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q      <= 1'b0;
      wait_q      <= 1'b0;
      region_q    <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        pend_q   <= 1'b1;
        wait_q   <= 1'b1;
        region_q <= region;
      end
      if (wait_q && dev_valid) begin
        wait_q      <= 1'b0;
        rsp_valid_q <= 1'b1;
      end
      // response leaves once the host takes it
      if (rsp_valid_q && host_req_i.d_ready) begin
        rsp_valid_q <= 1'b0;
        pend_q      <= 1'b0;
      end
    end
  end

  // held unchanged while the host stalls
  always_ff @(posedge clk_i) begin
    if (wait_q && dev_valid) begin
      rsp_rdata_q <= dev_rdata;
      rsp_error_q <= dev_error;
    end
  end

  assign host_rsp_o.a_ready = ~pend_q;
  assign host_rsp_o.d_valid = rsp_valid_q;
  assign host_rsp_o.d_rdata = rsp_rdata_q;
  assign host_rsp_o.d_error = rsp_error_q;

endmodule

// File: rtl/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  // host to crossbar, request and response-ready in one struct
  typedef struct packed {
    logic                   a_valid;
    logic                   a_write;
    logic [`SOC_ADDR_W-1:0] a_addr;
    logic [`SOC_DATA_W-1:0] a_wdata;
    logic                   d_ready;
  } bus_req_t;

  // crossbar to host
  typedef struct packed {
    logic                   a_ready;
    logic                   d_valid;
    logic [`SOC_DATA_W-1:0] d_rdata;
    logic                   d_error;
  } bus_rsp_t;

  // crossbar to device, valid is a single-cycle pulse
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`SOC_OFFS_W-1:0] offs;
    logic [`SOC_DATA_W-1:0] wdata;
  } dev_req_t;

  // device to crossbar, one cycle after the request
  typedef struct packed {
    logic                   valid;
    logic [`SOC_DATA_W-1:0] rdata;
  } dev_rsp_t;

  // timer register block to counter
  typedef struct packed {
    logic                   enable;
    logic                   load;
    logic [`SOC_DATA_W-1:0] load_value;
    logic [`SOC_DATA_W-1:0] compare;
  } timer_cfg_t;

  // counter back to the register block
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] count;
    logic                   match;
  } timer_stat_t;

endpackage

// File: rtl/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus and data widths
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

// offset inside one device region
`define SOC_OFFS_W 12

// default depth of the data memory in words
`define SOC_MEM_WORDS 256

// number of gpio pins
`define SOC_GPIO_W 16

// region codes taken from address bits 13:12, code 3 is unmapped
`define SOC_REGION_MEM   2'd0
`define SOC_REGION_TIMER 2'd1
`define SOC_REGION_GPIO  2'd2

`endif
